// File: vlog.f
+incdir+common
common/mmuPkg.sv
verilog/mmuApbRegs.sv
verilog/segmentTable.sv
mmu/addrTranslate.sv
verilog/mmuTop.sv
verif/mmuTb.sv

// File: Bender.yml
package:
  name: mmu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mmuPkg.sv
      - verilog/mmuApbRegs.sv
      - verilog/segmentTable.sv
      - mmu/addrTranslate.sv
      - verilog/mmuTop.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/mmuTb.sv

// File: verif/mmuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmuTb;

	localparam time CLK_PERIOD = 100ns;
	localparam int RESET_CYCLES = 2;
	localparam int NUM_APB = 49; // APB transfers issued over all tests
	localparam int NUM_XLATE = 21; // Paired fetch and data requests
	localparam int NUM_STROBE = 3;
	// Three cycles per APB transfer and two per request or strobe with twice that as margin
	localparam int RUN_CYCLES = 2 * (RESET_CYCLES + 3 * NUM_APB + 2 * NUM_XLATE
		+ 2 * NUM_STROBE) + 20;

	// Word order inside a 16-byte process block
	localparam int IM_LO = 0;
	localparam int IM_UP = 1;
	localparam int DM_LO = 2;
	localparam int DM_UP = 3;

	logic clk;
	logic arstN;
	mmuPkg::apbReqT apbReq;
	mmuPkg::apbRspT apbRsp;
	logic enterUser;
	logic enterKernel;
	mmuPkg::xlateReqT fetchReq;
	mmuPkg::xlateReqT dataReq;
	mmuPkg::xlateRspT fetchRsp;
	mmuPkg::xlateRspT dataRsp;

	// Reference model of the mode, the selector and the segment table
	logic userMode;
	logic [`MMU_SEL_W-1:0] modelSel;
	logic [`MMU_ADDR_W-1:0] modelBounds [`MMU_NUM_PROCS][4];

	integer seed;
	int errorCount;
	string testName; // Shown in every error line

	mmuTop mmuTop_inst (
		.clk(clk),
		.arstN(arstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.enterUser(enterUser),
		.enterKernel(enterKernel),
		.fetchReq(fetchReq),
		.dataReq(dataReq),
		.fetchRsp(fetchRsp),
		.dataRsp(dataRsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Ends a run that stalls somewhere
	initial begin
		#(CLK_PERIOD * RUN_CYCLES);
		$display("Timeout: the tests did not finish within %0d cycles", RUN_CYCLES);
		$display(">>> FAIL");
		$fatal(1, "Watchdog expired");
	end

	task automatic compareValues(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("FAILED %s %s expected %h actual %h", testName, what, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "Mismatch in test %s", testName);
		end
	endtask

	function automatic logic [`MMU_ADDR_W-1:0] randAddr(input logic [`MMU_ADDR_W-1:0] mask);
		return $random(seed) & mask;
	endfunction

	function automatic logic [`MMU_APB_ADDR_W-1:0] boundAddr(input int proc, input int field);
		return `MMU_TABLE_BASE + proc * `MMU_PROC_BLOCK + field * 4;
	endfunction

	// Expected response as {fault, addr} from the translation rule
	function automatic logic [`MMU_ADDR_W:0] predict(input logic user,
		input logic [`MMU_ADDR_W-1:0] addr, input logic [`MMU_ADDR_W-1:0] lower,
		input logic [`MMU_ADDR_W-1:0] upper);
		logic [`MMU_ADDR_W:0] wide;
		logic [`MMU_ADDR_W-1:0] sum;
		wide = {1'b0, addr} + {1'b0, lower};
		sum = wide[`MMU_ADDR_W-1:0]; // Carry out is dropped
		if (!user) begin
			return {1'b0, addr};
		end else if (sum > upper) begin
			return {1'b1, {`MMU_ADDR_W{1'b0}}};
		end else begin
			return {1'b0, sum};
		end
	endfunction

	// Setup phase, access phase, then back to idle
	task automatic busTransfer(input logic write, input logic [`MMU_APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = write;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		@(negedge clk);
		apbReq.penable = 1'b1;
		#1;
		rdata = apbRsp.prdata; // Settled well before the access edge
		err = apbRsp.pslverr;
		compareValues("pready", 32'd1, {31'd0, apbRsp.pready});
		@(negedge clk);
		apbReq = '0;
	endtask

	task automatic regWrite(input logic [`MMU_APB_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic expErr);
		logic [31:0] rdata;
		logic err;
		busTransfer(1'b1, addr, data, rdata, err);
		compareValues("pslverr on write", {31'd0, expErr}, {31'd0, err});
	endtask

	task automatic regRead(input logic [`MMU_APB_ADDR_W-1:0] addr, input logic [31:0] expData,
		input logic expErr);
		logic [31:0] rdata;
		logic err;
		busTransfer(1'b0, addr, 32'd0, rdata, err);
		compareValues("pslverr on read", {31'd0, expErr}, {31'd0, err});
		if (!expErr) begin
			compareValues("read data", expData, rdata);
		end
	endtask

	task automatic writeBound(input int proc, input int field, input logic [`MMU_ADDR_W-1:0] value);
		regWrite(boundAddr(proc, field), {6'd0, value}, 1'b0);
		modelBounds[proc][field] = value;
	endtask

	task automatic writeSelector(input logic [31:0] value);
		if (value < `MMU_NUM_PROCS) begin
			regWrite(`MMU_REG_SEL, value, 1'b0);
			modelSel = value[`MMU_SEL_W-1:0];
		end else begin
			regWrite(`MMU_REG_SEL, value, 1'b1); // Rejected and the selector holds
		end
	endtask

	task automatic writeControl(input logic user);
		regWrite(`MMU_REG_CTRL, {31'd0, user}, 1'b0);
		userMode = user;
	endtask

	// One-cycle strobe pulse where kernel wins when both are high
	task automatic pulseStrobes(input logic user, input logic kernel);
		@(negedge clk);
		enterUser = user;
		enterKernel = kernel;
		@(negedge clk);
		enterUser = 1'b0;
		enterKernel = 1'b0;
		if (kernel) begin
			userMode = 1'b0;
		end else if (user) begin
			userMode = 1'b1;
		end
	endtask

	// Both streams at once with the response checked one cycle after the sampling edge
	task automatic translatePair(input logic [`MMU_ADDR_W-1:0] fAddr,
		input logic [`MMU_ADDR_W-1:0] dAddr);
		logic [`MMU_ADDR_W:0] fExp;
		logic [`MMU_ADDR_W:0] dExp;
		fExp = predict(userMode, fAddr, modelBounds[modelSel][IM_LO], modelBounds[modelSel][IM_UP]);
		dExp = predict(userMode, dAddr, modelBounds[modelSel][DM_LO], modelBounds[modelSel][DM_UP]);
		@(negedge clk);
		// No request was sampled in the cycle before so both streams are idle
		compareValues("fetch idle valid", 32'd0, {31'd0, fetchRsp.valid});
		compareValues("data idle valid", 32'd0, {31'd0, dataRsp.valid});
		fetchReq.valid = 1'b1;
		fetchReq.addr = fAddr;
		dataReq.valid = 1'b1;
		dataReq.addr = dAddr;
		@(negedge clk);
		fetchReq = '0;
		dataReq = '0;
		compareValues("fetch valid", 32'd1, {31'd0, fetchRsp.valid});
		compareValues("fetch addr", {6'd0, fExp[`MMU_ADDR_W-1:0]}, {6'd0, fetchRsp.addr});
		compareValues("fetch fault", {31'd0, fExp[`MMU_ADDR_W]}, {31'd0, fetchRsp.fault});
		compareValues("data valid", 32'd1, {31'd0, dataRsp.valid});
		compareValues("data addr", {6'd0, dExp[`MMU_ADDR_W-1:0]}, {6'd0, dataRsp.addr});
		compareValues("data fault", {31'd0, dExp[`MMU_ADDR_W]}, {31'd0, dataRsp.fault});
	endtask

	task automatic resetDefaults();
		testName = "resetDefaults";
		// Both fault flags leave reset cleared
		compareValues("fetch fault after reset", 32'd0, {31'd0, fetchRsp.fault});
		compareValues("data fault after reset", 32'd0, {31'd0, dataRsp.fault});
		regRead(`MMU_REG_CTRL, 32'd0, 1'b0); // Kernel after reset
		regRead(`MMU_REG_SEL, 32'd0, 1'b0);
		repeat (4) translatePair(randAddr('1), randAddr('1));
	endtask

	task automatic tableReadback();
		int procs [4];
		logic [`MMU_ADDR_W-1:0] lower;
		testName = "tableReadback";
		procs = '{1, 3, 7, 10};
		foreach (procs[i]) begin
			// Segments of 1 MiB at random places below 16 MiB
			lower = randAddr(26'h0FF_FFFF);
			writeBound(procs[i], IM_LO, lower);
			writeBound(procs[i], IM_UP, lower + 26'h00F_FFFF);
			lower = randAddr(26'h0FF_FFFF);
			writeBound(procs[i], DM_LO, lower);
			writeBound(procs[i], DM_UP, lower + 26'h00F_FFFF);
			for (int f = 0; f < 4; f++) begin
				regRead(boundAddr(procs[i], f), {6'd0, modelBounds[procs[i]][f]}, 1'b0);
			end
		end
		writeSelector(32'd3);
		regRead(`MMU_REG_SEL, 32'd3, 1'b0);
	endtask

	task automatic userRelocation();
		testName = "userRelocation";
		writeControl(1'b1);
		regRead(`MMU_REG_CTRL, 32'd1, 1'b0);
		// Offsets up to 2 MiB so about half land past the 1 MiB segment
		repeat (6) translatePair(randAddr(26'h01F_FFFF), randAddr(26'h01F_FFFF));
		writeSelector(32'd7);
		repeat (6) translatePair(randAddr(26'h01F_FFFF), randAddr(26'h01F_FFFF));
	endtask

	task automatic boundaryFaults();
		logic [`MMU_ADDR_W-1:0] fSpan;
		logic [`MMU_ADDR_W-1:0] dSpan;
		testName = "boundaryFaults";
		fSpan = modelBounds[modelSel][IM_UP] - modelBounds[modelSel][IM_LO];
		dSpan = modelBounds[modelSel][DM_UP] - modelBounds[modelSel][DM_LO];
		translatePair(fSpan, dSpan); // Lands on the upper bound itself
		translatePair(fSpan + 1'b1, dSpan + 1'b1); // One past it
	endtask

	task automatic errorResponses();
		testName = "errorResponses";
		regWrite(12'h008, $random(seed), 1'b1);
		regRead(12'h050, 32'd0, 1'b1);
		regRead(boundAddr(`MMU_NUM_PROCS, IM_LO), 32'd0, 1'b1); // Just past the table
		regRead(`MMU_TABLE_BASE + 12'h002, 32'd0, 1'b1); // Misaligned word
		writeSelector(`MMU_NUM_PROCS);
		writeSelector(32'd15);
		regRead(`MMU_REG_SEL, {28'd0, modelSel}, 1'b0);
	endtask

	task automatic modeStrobes();
		testName = "modeStrobes";
		pulseStrobes(1'b0, 1'b1);
		regRead(`MMU_REG_CTRL, 32'd0, 1'b0);
		translatePair(randAddr(26'h01F_FFFF), randAddr(26'h01F_FFFF)); // Bypassed
		pulseStrobes(1'b1, 1'b0);
		regRead(`MMU_REG_CTRL, 32'd1, 1'b0);
		translatePair(randAddr(26'h01F_FFFF), randAddr(26'h01F_FFFF)); // Relocated
		pulseStrobes(1'b1, 1'b1);
		regRead(`MMU_REG_CTRL, 32'd0, 1'b0);
		translatePair(randAddr(26'h01F_FFFF), randAddr(26'h01F_FFFF));
	endtask

	initial begin
		seed = 32'h8b0454cb;
		errorCount = 0;
		testName = "init";
		userMode = 1'b0;
		modelSel = '0;
		for (int p = 0; p < `MMU_NUM_PROCS; p++) begin
			for (int f = 0; f < 4; f++) begin
				modelBounds[p][f] = '0;
			end
		end
		arstN = 1'b0;
		apbReq = '0;
		enterUser = 1'b0;
		enterKernel = 1'b0;
		fetchReq = '0;
		dataReq = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		resetDefaults();
		tableReadback();
		userRelocation();
		boundaryFaults();
		errorResponses();
		modeStrobes();
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/mmuTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmuTop (
	input wire logic clk,
	input wire logic arstN,
	input mmuPkg::apbReqT apbReq, // Register access from the kernel
	output mmuPkg::apbRspT apbRsp,
	input wire logic enterUser,
	input wire logic enterKernel,
	input mmuPkg::xlateReqT fetchReq, // Instruction fetch stream
	input mmuPkg::xlateReqT dataReq, // Load and store stream
	output mmuPkg::xlateRspT fetchRsp,
	output mmuPkg::xlateRspT dataRsp
);

	mmuPkg::tableWrT tableWr;
	logic [`MMU_SEL_W-1:0] rdProc;
	mmuPkg::segFieldT rdField;
	logic [`MMU_ADDR_W-1:0] rdData;
	logic [`MMU_SEL_W-1:0] selector;
	mmuPkg::execModeT mode;
	mmuPkg::segBoundsT bounds; // Bounds of the process picked by the selector

	// Register file and mode control
	mmuApbRegs mmuApbRegs_inst (
		.clk(clk),
		.arstN(arstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.enterUser(enterUser),
		.enterKernel(enterKernel),
		.tableWr(tableWr),
		.rdProc(rdProc),
		.rdField(rdField),
		.rdData(rdData),
		.selector(selector),
		.mode(mode)
	);

	// Bounds of every process
	segmentTable segmentTable_inst (
		.clk(clk),
		.arstN(arstN),
		.tableWr(tableWr),
		.rdProc(rdProc),
		.rdField(rdField),
		.rdData(rdData),
		.selector(selector),
		.bounds(bounds)
	);

	// One cycle translation of both streams
	addrTranslate addrTranslate_inst (
		.clk(clk),
		.arstN(arstN),
		.mode(mode),
		.bounds(bounds),
		.fetchReq(fetchReq),
		.dataReq(dataReq),
		.fetchRsp(fetchRsp),
		.dataRsp(dataRsp)
	);

endmodule

`default_nettype wire

// File: mmu/addrTranslate.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module addrTranslate (
	input wire logic clk,
	input wire logic arstN,
	input mmuPkg::execModeT mode,
	input mmuPkg::segBoundsT bounds, // Bounds of the running process
	input mmuPkg::xlateReqT fetchReq,
	input mmuPkg::xlateReqT dataReq,
	output mmuPkg::xlateRspT fetchRsp,
	output mmuPkg::xlateRspT dataRsp
);

	// Translation of one request against one segment
	// Kernel accesses bypass the relocation entirely
	function automatic mmuPkg::xlateRspT xlate(
		input mmuPkg::xlateReqT req,
		input mmuPkg::execModeT md,
		input logic [`MMU_ADDR_W-1:0] lower,
		input logic [`MMU_ADDR_W-1:0] upper
	);
		logic [`MMU_ADDR_W-1:0] sum;
		logic over;
		mmuPkg::xlateRspT rsp;

		sum = req.addr + lower; // Wraps modulo the address space
		over = (sum > upper); // The upper bound itself is still inside the segment
		rsp.valid = req.valid;
		if (md == mmuPkg::KERNEL) begin
			rsp.addr = req.addr;
			rsp.fault = 1'b0;
		end else begin
			rsp.addr = over ? '0 : sum; // Nothing leaks past a faulting access
			rsp.fault = req.valid & over;
		end
		return rsp;
	endfunction

	mmuPkg::xlateRspT fetchNext;
	mmuPkg::xlateRspT dataNext;

	logic fetchValidQ;
	logic fetchFaultQ;
	logic [`MMU_ADDR_W-1:0] fetchAddrQ;
	logic dataValidQ;
	logic dataFaultQ;
	logic [`MMU_ADDR_W-1:0] dataAddrQ;

	// Each stream has its own adder and comparator
	assign fetchNext = xlate(fetchReq, mode, bounds.imLower, bounds.imUpper);
	assign dataNext = xlate(dataReq, mode, bounds.dmLower, bounds.dmUpper);

	// Control bits of the response stage
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fetchValidQ <= 1'b0;
			fetchFaultQ <= 1'b0;
			dataValidQ <= 1'b0;
			dataFaultQ <= 1'b0;
		end else begin
			fetchValidQ <= fetchNext.valid;
			fetchFaultQ <= fetchNext.fault;
			dataValidQ <= dataNext.valid;
			dataFaultQ <= dataNext.fault;
		end
	end

	// Address payload, qualified by the valid bits
	always_ff @(posedge clk) begin
		fetchAddrQ <= fetchNext.addr;
		dataAddrQ <= dataNext.addr;
	end

	always_comb begin
		fetchRsp.valid = fetchValidQ;
		fetchRsp.addr = fetchAddrQ;
		fetchRsp.fault = fetchFaultQ;
	end

	always_comb begin
		dataRsp.valid = dataValidQ;
		dataRsp.addr = dataAddrQ;
		dataRsp.fault = dataFaultQ;
	end

endmodule

`default_nettype wire

// File: verilog/segmentTable.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module segmentTable (
	input wire logic clk,
	input wire logic arstN,
	input mmuPkg::tableWrT tableWr,
	input wire logic [`MMU_SEL_W-1:0] rdProc, // Process block addressed by APB
	input mmuPkg::segFieldT rdField,
	output logic [`MMU_ADDR_W-1:0] rdData,
	input wire logic [`MMU_SEL_W-1:0] selector, // Running process
	output mmuPkg::segBoundsT bounds
);

	// One bounds entry per process slot
	mmuPkg::segBoundsT boundsMem [`MMU_NUM_PROCS];
	mmuPkg::segBoundsT rdEntry;

	// Software loads one bound word at a time
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `MMU_NUM_PROCS; i++) begin
				boundsMem[i] <= '0; // Every segment starts empty
			end
		end else if (tableWr.en) begin
			case (tableWr.field)
				mmuPkg::IM_LOWER: boundsMem[tableWr.proc].imLower <= tableWr.data;
				mmuPkg::IM_UPPER: boundsMem[tableWr.proc].imUpper <= tableWr.data;
				mmuPkg::DM_LOWER: boundsMem[tableWr.proc].dmLower <= tableWr.data;
				mmuPkg::DM_UPPER: boundsMem[tableWr.proc].dmUpper <= tableWr.data;
				default: ;
			endcase
		end
	end

	// The APB decode only maps valid blocks
	// Unused slots of the 4-bit index still read as zero
	assign rdEntry = (rdProc < `MMU_NUM_PROCS) ? boundsMem[rdProc] : '0;

	always_comb begin
		case (rdField)
			mmuPkg::IM_LOWER: rdData = rdEntry.imLower;
			mmuPkg::IM_UPPER: rdData = rdEntry.imUpper;
			mmuPkg::DM_LOWER: rdData = rdEntry.dmLower;
			mmuPkg::DM_UPPER: rdData = rdEntry.dmUpper;
			default: rdData = '0;
		endcase
	end

	// Selector writes are range checked so this index is always in the table
	assign bounds = boundsMem[selector];

endmodule

`default_nettype wire

// File: verilog/mmuApbRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmuApbRegs (
	input wire logic clk,
	input wire logic arstN,
	input mmuPkg::apbReqT apbReq,
	output mmuPkg::apbRspT apbRsp,
	input wire logic enterUser, // Strobe from the core on a return to user code
	input wire logic enterKernel, // Strobe from the core on a trap or syscall
	output mmuPkg::tableWrT tableWr,
	output logic [`MMU_SEL_W-1:0] rdProc,
	output mmuPkg::segFieldT rdField,
	input wire logic [`MMU_ADDR_W-1:0] rdData,
	output logic [`MMU_SEL_W-1:0] selector,
	output mmuPkg::execModeT mode
);

	logic access; // APB access phase
	logic wrAccess;
	logic isCtrl;
	logic isSel;
	logic isTable;
	logic mapped;
	logic selValid; // Written selector names an existing process
	logic [`MMU_APB_ADDR_W-1:0] tableOff; // Offset relative to the table base
	logic [`MMU_APB_DATA_W-1:0] rdMux;
	logic ctrlWr;
	logic selWr;

	assign access = apbReq.psel & apbReq.penable;
	assign wrAccess = access & apbReq.pwrite;

	// Register decode, only word aligned offsets are mapped
	assign isCtrl = (apbReq.paddr == `MMU_REG_CTRL);
	assign isSel = (apbReq.paddr == `MMU_REG_SEL);
	assign isTable = (apbReq.paddr >= `MMU_TABLE_BASE) &&
		(apbReq.paddr < `MMU_TABLE_BASE + `MMU_TABLE_SIZE) &&
		(apbReq.paddr[1:0] == 2'b00);
	assign mapped = isCtrl | isSel | isTable;

	// Split a table offset into the process block and the word inside it
	assign tableOff = apbReq.paddr - `MMU_TABLE_BASE;
	assign rdProc = tableOff[`MMU_SEL_W+3:4];
	assign rdField = mmuPkg::segFieldT'(tableOff[3:2]);

	assign selValid = (apbReq.pwdata < `MMU_NUM_PROCS);

	assign ctrlWr = wrAccess & isCtrl;
	assign selWr = wrAccess & isSel & selValid; // Out of range values never reach the register

	// Table writes go straight through to the storage and land at this edge
	always_comb begin
		tableWr.en = wrAccess & isTable;
		tableWr.proc = rdProc;
		tableWr.field = rdField;
		tableWr.data = apbReq.pwdata[`MMU_ADDR_W-1:0];
	end

	// Read mux for the access phase
	always_comb begin
		rdMux = '0;
		if (isCtrl) begin
			rdMux[0] = (mode == mmuPkg::USER);
		end else if (isSel) begin
			rdMux = {{(`MMU_APB_DATA_W-`MMU_SEL_W){1'b0}}, selector}; // Zero extended
		end else if (isTable) begin
			rdMux = {{(`MMU_APB_DATA_W-`MMU_ADDR_W){1'b0}}, rdData};
		end
	end

	always_comb begin
		apbRsp.prdata = rdMux;
		apbRsp.pready = 1'b1; // Zero wait states
		apbRsp.pslverr = access & (~mapped | (isSel & apbReq.pwrite & ~selValid));
	end

	// Mode register
	// The kernel strobe beats the user strobe and both beat software
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mode <= mmuPkg::KERNEL; // The core boots into the kernel
		end else if (enterKernel) begin
			mode <= mmuPkg::KERNEL;
		end else if (enterUser) begin
			mode <= mmuPkg::USER;
		end else if (ctrlWr) begin
			mode <= mmuPkg::execModeT'(apbReq.pwdata[0]); // Software can switch modes itself
		end
	end

	// Selector of the running process
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			selector <= '0;
		end else if (selWr) begin
			selector <= apbReq.pwdata[`MMU_SEL_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: common/mmuPkg.sv
`default_nettype none

`include "mmu_config.svh"

package mmuPkg;

	// Execution mode of the core, user mode relocates and checks every access
	typedef enum logic {
		KERNEL = 1'b0,
		USER = 1'b1
	} execModeT;

	// Word within a 16-byte process block of the segment table
	typedef enum logic [1:0] {
		IM_LOWER = 2'd0, // Offset 0x0
		IM_UPPER = 2'd1, // Offset 0x4
		DM_LOWER = 2'd2, // Offset 0x8
		DM_UPPER = 2'd3  // Offset 0xC
	} segFieldT;

	// Full set of bounds for one process
	typedef struct packed {
		logic [`MMU_ADDR_W-1:0] imLower;
		logic [`MMU_ADDR_W-1:0] imUpper;
		logic [`MMU_ADDR_W-1:0] dmLower;
		logic [`MMU_ADDR_W-1:0] dmUpper;
	} segBoundsT;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`MMU_APB_ADDR_W-1:0] paddr;
		logic [`MMU_APB_DATA_W-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [`MMU_APB_DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRspT;

	// One translation request from the core
	typedef struct packed {
		logic valid;
		logic [`MMU_ADDR_W-1:0] addr;
	} xlateReqT;

	typedef struct packed {
		logic valid;
		logic [`MMU_ADDR_W-1:0] addr; // Physical address, zero on a fault
		logic fault;
	} xlateRspT;

	// Write port into the segment table
	typedef struct packed {
		logic en;
		logic [`MMU_SEL_W-1:0] proc;
		segFieldT field;
		logic [`MMU_ADDR_W-1:0] data;
	} tableWrT;

endpackage

`default_nettype wire

// File: common/mmu_config.svh
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Width of logical and physical addresses as seen by the core
`define MMU_ADDR_W 26

// Process slots in the segment table and the width of the selector that picks one
`define MMU_NUM_PROCS 11
`define MMU_SEL_W 4

// APB bus widths
`define MMU_APB_ADDR_W 12
`define MMU_APB_DATA_W 32

// Register map offsets
`define MMU_REG_CTRL 12'h000 // Control and status with the mode in bit 0
`define MMU_REG_SEL 12'h004 // Running process selector
`define MMU_TABLE_BASE 12'h100 // First process block of the segment table

// Each process owns four 32-bit words in the table
`define MMU_PROC_BLOCK 16
`define MMU_TABLE_SIZE (`MMU_NUM_PROCS * `MMU_PROC_BLOCK)

`endif
